//--- Bender.yml
package:
  name: mpad_dma

export_include_dirs:
  - hdl

sources:
  # RTL, packages first
  - hdl/mpad_axi_pkg.sv
  - hdl/mpad_engine_pkg.sv
  - hdl/mpad_window_reader.sv
  - hdl/mpad_block_writer.sv
  - hdl/mpad_tile_ctrl.sv
  - hdl/mpad_dma_top.sv

  # Verification
  - target: test
    files:
      - dv/mpad_dma_asserts.sv
      - dv/mpad_dma_tb.sv

//--- dv/mpad_cases.txt
# name width src_base dst_base stall_pct writes
# bases in hex, writes is (N+2)*(N+2)
n4_clean 4 00001000 00008000 0 36
n6_stall 6 00002000 00009000 30 64
n8_stall 8 00003000 0000a000 30 100
n8_b2b 8 00004000 0000c000 30 100
n4_stall 4 00005000 0000d000 30 36
n32_light 32 00010000 00020000 10 1156

//--- dv/mpad_dma_asserts.sv
/*
 * AXI handshake assertions bound to the DMA top
 */
`timescale 1ns/1ps

module mpad_dma_asserts (
    input  logic                clk,
    input  logic                rst_n,
    input  mpad_axi_pkg::addr_t araddr_o,
    input  mpad_axi_pkg::len_t  arlen_o,
    input  logic                arvalid_o,
    input  logic                arready_i,
    input  mpad_axi_pkg::addr_t awaddr_o,
    input  logic                awvalid_o,
    input  logic                awready_i,
    input  mpad_axi_pkg::data_t wdata_o,
    input  logic                wlast_o,
    input  logic                wvalid_o,
    input  logic                wready_i
);

    int fail_count = 0;   // Failed assertion count

    // Valid holds with a stable payload until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o))
        else begin
            $error("arvalid dropped or AR payload changed before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else begin
            $error("awvalid dropped or awaddr changed before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wlast_o))
        else begin
            $error("wvalid dropped or W payload changed before wready");
            fail_count++;
        end

    // Every write is a single beat
    w_last: assert property (@(posedge clk) disable iff (!rst_n) wvalid_o |-> wlast_o)
        else begin
            $error("wvalid high without wlast");
            fail_count++;
        end

endmodule

bind mpad_dma_top mpad_dma_asserts u_dma_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .araddr_o  (araddr_o),
    .arlen_o   (arlen_o),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .awaddr_o  (awaddr_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .wdata_o   (wdata_o),
    .wlast_o   (wlast_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i)
);

//--- dv/mpad_dma_tb.sv
/*
 * Testbench for the mirror-padding DMA with clock and reset, an AXI
 * memory model with random stalls, stimulus from the cases file and checks
 */
`timescale 1ns/1ps
`include "mpad_macros.svh"

module mpad_dma_tb;

    localparam int TIMEOUT_CYCLES = 100000;
    localparam int MAX_WORDS      = 1024;
    localparam int AR_LEN_EXP     = 2;   // Three beats per burst

    logic clk;
    logic rst_n;
    mpad_axi_pkg::addr_t     src_addr;
    mpad_axi_pkg::addr_t     dst_addr;
    mpad_engine_pkg::width_t mat_width;
    logic                    start;
    logic                    done;
    mpad_axi_pkg::addr_t     araddr;
    mpad_axi_pkg::len_t      arlen;
    logic                    arvalid;
    logic                    arready;
    logic                    rlast;
    logic                    rvalid;
    logic                    rready;
    mpad_axi_pkg::data_t     rdata;
    mpad_axi_pkg::addr_t     awaddr;
    logic                    awvalid;
    logic                    awready;
    logic                    wlast;
    logic                    wvalid;
    logic                    wready;
    logic                    bvalid;
    logic                    bready;
    mpad_axi_pkg::data_t     wdata;

    logic [31:0] mem [logic [31:0]];   // Word addressed
    logic [31:0] src_words [MAX_WORDS];
    logic [31:0] data_state  = 32'd17;
    logic [31:0] stall_state = 32'd17;
    int          stall_pct   = 0;
    string       cur_name    = "reset";
    logic [31:0] cur_src     = '0;
    logic [31:0] cur_dst     = '0;
    int          cur_n       = 4;
    int          write_count = 0;
    int          error_count = 0;
    int          tests_run   = 0;
    int          tests_failed = 0;
    logic        timed_out   = 1'b0;

    // Memory model state for the one outstanding burst or write
    logic        rd_active;
    logic        aw_pending;
    logic        b_pending;
    logic [31:0] rd_word;
    logic [31:0] wr_addr;
    int          rd_beat;
    int          rd_beats;   // Burst length taken from arlen
    logic        ar_fire;
    logic        r_fire;
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    logic [31:0] ar_addr_s;
    logic [31:0] aw_addr_s;
    logic [31:0] w_data_s;
    logic [3:0]  ar_len_s;
    logic        w_last_s;

    mpad_dma_top u_mpad_dma_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_addr_i  (src_addr),
        .dst_addr_i  (dst_addr),
        .mat_width_i (mat_width),
        .start_i     (start),
        .done_o      (done),
        .araddr_o    (araddr),
        .arlen_o     (arlen),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .rdata_i     (rdata),
        .rlast_i     (rlast),
        .rvalid_i    (rvalid),
        .rready_o    (rready),
        .awaddr_o    (awaddr),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .wdata_o     (wdata),
        .wlast_o     (wlast),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .bvalid_i    (bvalid),
        .bready_o    (bready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    // High unless this cycle is a stall
    function automatic logic ready_roll();
        stall_state = xorshift32(stall_state);
        return (stall_state % 100) >= stall_pct;
    endfunction

    // Border index reflects the first interior neighbour
    function automatic int mirror_index(input int o, input int n);
        if (o == 0) return 1;
        else if (o == n + 1) return n - 2;
        else return o - 1;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // AXI slave memory samples handshakes at the falling edge
    initial begin
        logic [31:0] off;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        rd_active = 1'b0;
        aw_pending = 1'b0;
        b_pending = 1'b0;
        rd_word = '0;
        wr_addr = '0;
        rd_beat = 0;
        rd_beats = 1;
        forever begin
            @(negedge clk);
            ar_fire = arvalid && arready;
            r_fire  = rvalid && rready;
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            b_fire  = bvalid && bready;
            ar_addr_s = araddr;
            ar_len_s  = arlen;
            aw_addr_s = awaddr;
            w_data_s  = wdata;
            w_last_s  = wlast;
            @(posedge clk);
            #1;
            if (b_fire) b_pending = 1'b0;
            if (w_fire) begin
                off = wr_addr - cur_dst;
                assert (off[1:0] == 2'b00 && off < (cur_n + 2) * (cur_n + 2) * 4) else begin
                    $display("%s: write to %h lies outside the destination region",
                             cur_name, wr_addr);
                    error_count++;
                end
                assert (w_last_s) else begin
                    $display("%s: write data beat arrived without wlast", cur_name);
                    error_count++;
                end
                mem[wr_addr >> 2] = w_data_s;
                write_count++;
                aw_pending = 1'b0;
                b_pending  = 1'b1;
            end
            if (aw_fire) begin
                wr_addr    = aw_addr_s;
                aw_pending = 1'b1;
            end
            if (r_fire) begin
                rd_beat++;
                if (rd_beat == rd_beats) rd_active = 1'b0;
            end
            if (ar_fire) begin
                off = ar_addr_s - cur_src;
                assert (ar_len_s == AR_LEN_EXP) else begin
                    $display("FAILED %s arlen expected %0d actual %0d",
                             cur_name, AR_LEN_EXP, ar_len_s);
                    error_count++;
                end
                assert (off[1:0] == 2'b00 && (off >> 2) / cur_n < cur_n
                        && (off >> 2) % cur_n <= cur_n - `MPAD_WIN_DIM) else begin
                    $display("%s: read burst at %h lies outside the source matrix",
                             cur_name, ar_addr_s);
                    error_count++;
                end
                rd_word   = ar_addr_s >> 2;
                rd_beat   = 0;
                rd_beats  = ar_len_s + 1;
                rd_active = 1'b1;
            end
            arready = rd_active ? 1'b0 : ready_roll();
            if (rd_active) begin
                if (!(rvalid && !r_fire)) rvalid = ready_roll();   // Hold until taken
                rdata = mem.exists(rd_word + rd_beat) ? mem[rd_word + rd_beat] : '0;
                rlast = (rd_beat == rd_beats - 1);
            end else begin
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
            awready = (aw_pending || b_pending) ? 1'b0 : ready_roll();
            wready  = aw_pending ? ready_roll() : 1'b0;
            if (b_pending) begin
                if (!(bvalid && !b_fire)) bvalid = ready_roll();
            end else begin
                bvalid = 1'b0;
            end
        end
    end

    task automatic run_case(input string name, input int n, input logic [31:0] src_b,
                            input logic [31:0] dst_b, input int pct, input int exp_w);
        int          errs_before;
        int          cycles;
        logic [31:0] key;
        logic [31:0] exp;
        errs_before = error_count;
        for (int i = 0; i < n * n; i++) begin
            data_state = xorshift32(data_state);
            src_words[i] = data_state;
            mem[(src_b >> 2) + i] = data_state;
        end
        for (int i = 0; i < (n + 2) * (n + 2); i++) begin
            mem.delete((dst_b >> 2) + i);
        end
        cur_name = name;
        cur_n = n;
        cur_src = src_b;
        cur_dst = dst_b;
        stall_pct = pct;
        write_count = 0;
        src_addr = src_b;
        dst_addr = dst_b;
        mat_width = mpad_engine_pkg::width_t'(n);
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        assert (done == 1'b0) else begin
            $display("FAILED %s done_o expected 0 actual %b", name, done);
            error_count++;
        end
        cycles = 0;
        while (done !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("%s: timed out after %0d cycles waiting for done_o", name, cycles);
            timed_out = 1'b1;
            tests_run++;
            tests_failed++;
        end else begin
            assert (write_count == exp_w && exp_w == (n + 2) * (n + 2)) else begin
                $display("FAILED %s write count expected %0d actual %0d",
                         name, (n + 2) * (n + 2), write_count);
                error_count++;
            end
            for (int r = 0; r < n + 2; r++) begin
                for (int c = 0; c < n + 2; c++) begin
                    key = (dst_b >> 2) + r * (n + 2) + c;
                    exp = src_words[mirror_index(r, n) * n + mirror_index(c, n)];
                    assert (mem.exists(key)) else begin
                        $display("%s: output word (%0d,%0d) was never written", name, r, c);
                        error_count++;
                    end
                    if (mem.exists(key)) begin
                        assert (mem[key] == exp) else begin
                            $display("FAILED %s word (%0d,%0d) expected %h actual %h",
                                     name, r, c, exp, mem[key]);
                            error_count++;
                        end
                    end
                end
            end
            tests_run++;
            if (error_count != errs_before) tests_failed++;
            $display("%-10s %s  writes %0d  cycles %0d", name,
                     (error_count == errs_before) ? "PASS" : "FAIL", write_count, cycles);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          nf;
        int          width;
        int          pct;
        int          exp_w;
        int          assert_fails;
        string       line;
        string       name;
        logic [31:0] src_b;
        logic [31:0] dst_b;
        rst_n = 1'b0;
        start = 1'b0;
        src_addr = '0;
        dst_addr = '0;
        mat_width = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tests_run++;
        assert (!arvalid && !rready && !awvalid && !wvalid && !wlast && !bready && done)
        else begin
            $display("reset: handshake outputs not idle or done_o low after reset");
            error_count++;
            tests_failed++;
        end
        $display("%-10s %s", "reset", (error_count == 0) ? "PASS" : "FAIL");
        fd = $fopen("dv/mpad_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file dv/mpad_cases.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line[0] == "#") continue;
                nf = $sscanf(line, "%s %d %h %h %d %d", name, width, src_b, dst_b, pct, exp_w);
                if (nf != 6) begin
                    $display("malformed line in cases file: %s", line);
                    error_count++;
                    continue;
                end
                run_case(name, width, src_b, dst_b, pct, exp_w);   // Back to back
            end
            $fclose(fd);
        end
        assert_fails = u_mpad_dma_top.u_dma_asserts.fail_count;
        $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count,
                 assert_fails);
        if (tests_failed == 0 && error_count == 0 && !timed_out && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- hdl/mpad_axi_pkg.sv
/*
 * Bus-side types for the AXI read and write ports
 */
`include "mpad_macros.svh"

package mpad_axi_pkg;

    typedef logic [`MPAD_ADDR_W-1:0] addr_t;   // Byte address
    typedef logic [`MPAD_DATA_W-1:0] data_t;

    // AXI3 burst length, beats minus one
    typedef logic [3:0] len_t;

endpackage

//--- hdl/mpad_block_writer.sv
/*
 * Block writer: four single-beat AXI writes for one 2x2 output block
 */
`timescale 1ns/1ps
`include "mpad_macros.svh"

module mpad_block_writer (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    store_req_i,
    input  mpad_axi_pkg::addr_t     blk_addr_i,
    input  mpad_axi_pkg::addr_t     out_pitch_i,
    input  mpad_engine_pkg::block_t blk_i,
    output logic                    store_done_o,

    output mpad_axi_pkg::addr_t     awaddr_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output mpad_axi_pkg::data_t     wdata_o,
    output logic                    wlast_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic                    bvalid_i,
    output logic                    bready_o
);

    mpad_engine_pkg::wr_state_e state_q;
    logic [1:0]                 word_q;    // TL, TR, BL, BR
    logic                       done_q;
    mpad_axi_pkg::addr_t        base_q;
    mpad_axi_pkg::addr_t        pitch_q;
    mpad_engine_pkg::block_t    blk_q;

    mpad_axi_pkg::addr_t row_off;
    mpad_axi_pkg::addr_t col_off;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mpad_engine_pkg::WR_IDLE;
            word_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                mpad_engine_pkg::WR_IDLE: begin
                    if (store_req_i) begin
                        word_q  <= '0;
                        state_q <= mpad_engine_pkg::WR_ADDR;
                    end
                end
                mpad_engine_pkg::WR_ADDR: begin
                    if (awready_i) state_q <= mpad_engine_pkg::WR_DATA;
                end
                mpad_engine_pkg::WR_DATA: begin
                    if (wready_i) state_q <= mpad_engine_pkg::WR_RESP;
                end
                mpad_engine_pkg::WR_RESP: begin
                    if (bvalid_i && word_q == 2'(`MPAD_BLK_WORDS - 1)) begin
                        done_q  <= 1'b1;
                        state_q <= mpad_engine_pkg::WR_IDLE;
                    end else if (bvalid_i) begin
                        word_q  <= word_q + 2'd1;
                        state_q <= mpad_engine_pkg::WR_ADDR;
                    end
                end
                default: state_q <= mpad_engine_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mpad_engine_pkg::WR_IDLE && store_req_i) begin
            base_q  <= blk_addr_i;
            pitch_q <= out_pitch_i;
            blk_q   <= blk_i;
        end
    end

    // Bottom row one pitch down, right column one word over
    assign row_off = word_q[1] ? pitch_q : '0;
    assign col_off = word_q[0] ? mpad_axi_pkg::addr_t'(`MPAD_WORD_BYTES) : '0;

    assign awaddr_o  = base_q + row_off + col_off;
    assign awvalid_o = (state_q == mpad_engine_pkg::WR_ADDR);
    assign wdata_o   = blk_q[word_q];
    assign wvalid_o  = (state_q == mpad_engine_pkg::WR_DATA);
    assign wlast_o   = (state_q == mpad_engine_pkg::WR_DATA);   // Single beat
    assign bready_o  = (state_q == mpad_engine_pkg::WR_RESP);

    assign store_done_o = done_q;

endmodule

//--- hdl/mpad_dma_top.sv
/*
 * Mirror-padding DMA top: controller, window reader, block writer
 */
`timescale 1ns/1ps

module mpad_dma_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Configuration
    input  mpad_axi_pkg::addr_t     src_addr_i,
    input  mpad_axi_pkg::addr_t     dst_addr_i,
    input  mpad_engine_pkg::width_t mat_width_i,
    input  logic                    start_i,
    output logic                    done_o,

    // AR and R
    output mpad_axi_pkg::addr_t     araddr_o,
    output mpad_axi_pkg::len_t      arlen_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  mpad_axi_pkg::data_t     rdata_i,
    input  logic                    rlast_i,
    input  logic                    rvalid_i,
    output logic                    rready_o,

    // AW, W and B
    output mpad_axi_pkg::addr_t     awaddr_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output mpad_axi_pkg::data_t     wdata_o,
    output logic                    wlast_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic                    bvalid_i,
    output logic                    bready_o
);

    logic                     fetch_req;
    logic                     fetch_done;
    mpad_axi_pkg::addr_t      win_addr;
    mpad_axi_pkg::addr_t      row_pitch;
    mpad_engine_pkg::window_t win;

    logic                     store_req;
    logic                     store_done;
    mpad_axi_pkg::addr_t      blk_addr;
    mpad_axi_pkg::addr_t      out_pitch;
    mpad_engine_pkg::block_t  blk;

    mpad_tile_ctrl u_tile_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .mat_width_i  (mat_width_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .fetch_req_o  (fetch_req),
        .win_addr_o   (win_addr),
        .row_pitch_o  (row_pitch),
        .fetch_done_i (fetch_done),
        .win_i        (win),
        .store_req_o  (store_req),
        .blk_addr_o   (blk_addr),
        .out_pitch_o  (out_pitch),
        .blk_o        (blk),
        .store_done_i (store_done)
    );

    mpad_window_reader u_window_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req_i  (fetch_req),
        .win_addr_i   (win_addr),
        .row_pitch_i  (row_pitch),
        .fetch_done_o (fetch_done),
        .win_o        (win),
        .araddr_o     (araddr_o),
        .arlen_o      (arlen_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .rdata_i      (rdata_i),
        .rlast_i      (rlast_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o)
    );

    mpad_block_writer u_block_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .store_req_i  (store_req),
        .blk_addr_i   (blk_addr),
        .out_pitch_i  (out_pitch),
        .blk_i        (blk),
        .store_done_o (store_done),
        .awaddr_o     (awaddr_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .wdata_o      (wdata_o),
        .wlast_o      (wlast_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o)
    );

endmodule

//--- hdl/mpad_engine_pkg.sv
/*
 * Engine-side types: FSM state enums, matrix index,
 * 3x3 source window and 2x2 output block
 */
`include "mpad_macros.svh"

package mpad_engine_pkg;

    // Block sequencing
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        BUILD,
        STORE,
        ADVANCE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    // One AW/W/B round per word
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef logic [`MPAD_WIDTH_W-1:0] width_t;

    // Raster order, index is row * 3 + col
    typedef mpad_axi_pkg::data_t [`MPAD_WIN_WORDS-1:0] window_t;
    typedef mpad_axi_pkg::data_t [`MPAD_BLK_WORDS-1:0] block_t;   // [0] is TL

endpackage

//--- hdl/mpad_macros.svh
/*
 * Bus widths, matrix size field and window/block dimensions
 */
`ifndef MPAD_MACROS_SVH
`define MPAD_MACROS_SVH

// AXI side
`define MPAD_ADDR_W      32
`define MPAD_DATA_W      32
`define MPAD_WORD_BYTES  4    // Address step per word

// Matrix size field, holds N up to 32 and N+2
`define MPAD_WIDTH_W     6

// Source window, also beats per read burst
`define MPAD_WIN_DIM     3
`define MPAD_WIN_WORDS   9

`define MPAD_BLK_WORDS   4    // TL, TR, BL, BR

`endif

//--- hdl/mpad_tile_ctrl.sv
/*
 * Tile controller: walks the 2x2 output blocks, places the clamped
 * source window, applies the mirror rule and sequences reader and writer
 */
`timescale 1ns/1ps
`include "mpad_macros.svh"

module mpad_tile_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,

    input  mpad_axi_pkg::addr_t      src_addr_i,
    input  mpad_axi_pkg::addr_t      dst_addr_i,
    input  mpad_engine_pkg::width_t  mat_width_i,
    input  logic                     start_i,
    output logic                     done_o,

    output logic                     fetch_req_o,
    output mpad_axi_pkg::addr_t      win_addr_o,
    output mpad_axi_pkg::addr_t      row_pitch_o,
    input  logic                     fetch_done_i,
    input  mpad_engine_pkg::window_t win_i,

    output logic                     store_req_o,
    output mpad_axi_pkg::addr_t      blk_addr_o,
    output mpad_axi_pkg::addr_t      out_pitch_o,
    output mpad_engine_pkg::block_t  blk_o,
    input  logic                     store_done_i
);

    mpad_engine_pkg::ctrl_state_e state_q;
    logic                         done_q;
    logic                         fetch_req_q;
    logic                         store_req_q;
    mpad_engine_pkg::width_t      blk_row_q;   // Output row of TL
    mpad_engine_pkg::width_t      blk_col_q;
    mpad_axi_pkg::addr_t          src_q;
    mpad_axi_pkg::addr_t          dst_q;
    mpad_engine_pkg::width_t      n_q;
    mpad_engine_pkg::block_t      blk_q;

    mpad_engine_pkg::width_t win_row;
    mpad_engine_pkg::width_t win_col;
    logic                    last_blk;

    // Window starts one before the block, kept inside 0..N-3
    function automatic mpad_engine_pkg::width_t win_origin(
        input mpad_engine_pkg::width_t b,
        input mpad_engine_pkg::width_t n
    );
        mpad_engine_pkg::width_t lim;
        lim = n - mpad_engine_pkg::width_t'(`MPAD_WIN_DIM);
        if (b == '0) return '0;
        else if (b - 6'd1 > lim) return lim;
        else return b - 6'd1;
    endfunction

    // Mirror rule, edge rows and columns reflect without the edge itself
    function automatic mpad_engine_pkg::width_t src_index(
        input mpad_engine_pkg::width_t o,
        input mpad_engine_pkg::width_t n
    );
        if (o == '0) return 6'd1;
        else if (o == n + 6'd1) return n - 6'd2;
        else return o - 6'd1;
    endfunction

    function automatic mpad_axi_pkg::data_t pick(
        input mpad_engine_pkg::width_t o_row,
        input mpad_engine_pkg::width_t o_col
    );
        mpad_engine_pkg::width_t r;
        mpad_engine_pkg::width_t c;
        logic [3:0]              idx;
        r   = src_index(o_row, n_q) - win_row;   // 0..2 inside the window
        c   = src_index(o_col, n_q) - win_col;
        idx = 4'(r * `MPAD_WIN_DIM + c);
        return win_i[idx];
    endfunction

    assign win_row  = win_origin(blk_row_q, n_q);
    assign win_col  = win_origin(blk_col_q, n_q);
    assign last_blk = (blk_row_q == n_q) && (blk_col_q == n_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= mpad_engine_pkg::IDLE;
            done_q      <= 1'b1;
            fetch_req_q <= 1'b0;
            store_req_q <= 1'b0;
            blk_row_q   <= '0;
            blk_col_q   <= '0;
        end else begin
            fetch_req_q <= 1'b0;
            store_req_q <= 1'b0;
            case (state_q)
                mpad_engine_pkg::IDLE: begin
                    if (start_i) begin
                        done_q      <= 1'b0;
                        blk_row_q   <= '0;
                        blk_col_q   <= '0;
                        fetch_req_q <= 1'b1;
                        state_q     <= mpad_engine_pkg::FETCH;
                    end
                end
                mpad_engine_pkg::FETCH: begin
                    if (fetch_done_i) state_q <= mpad_engine_pkg::BUILD;
                end
                mpad_engine_pkg::BUILD: begin
                    store_req_q <= 1'b1;   // Block words registered this cycle
                    state_q     <= mpad_engine_pkg::STORE;
                end
                mpad_engine_pkg::STORE: begin
                    if (store_done_i) state_q <= mpad_engine_pkg::ADVANCE;
                end
                mpad_engine_pkg::ADVANCE: begin
                    if (last_blk) begin
                        done_q  <= 1'b1;
                        state_q <= mpad_engine_pkg::IDLE;
                    end else begin
                        if (blk_col_q == n_q) begin
                            blk_col_q <= '0;
                            blk_row_q <= blk_row_q + 6'd2;
                        end else begin
                            blk_col_q <= blk_col_q + 6'd2;
                        end
                        fetch_req_q <= 1'b1;
                        state_q     <= mpad_engine_pkg::FETCH;
                    end
                end
                default: state_q <= mpad_engine_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mpad_engine_pkg::IDLE && start_i) begin
            src_q <= src_addr_i;
            dst_q <= dst_addr_i;
            n_q   <= mat_width_i;
        end
        if (state_q == mpad_engine_pkg::BUILD) begin
            blk_q[0] <= pick(blk_row_q, blk_col_q);
            blk_q[1] <= pick(blk_row_q, blk_col_q + 6'd1);
            blk_q[2] <= pick(blk_row_q + 6'd1, blk_col_q);
            blk_q[3] <= pick(blk_row_q + 6'd1, blk_col_q + 6'd1);
        end
    end

    assign row_pitch_o = mpad_axi_pkg::addr_t'(n_q) * `MPAD_WORD_BYTES;
    assign out_pitch_o = mpad_axi_pkg::addr_t'(n_q + 6'd2) * `MPAD_WORD_BYTES;

    assign win_addr_o = src_q + (mpad_axi_pkg::addr_t'(win_row) * mpad_axi_pkg::addr_t'(n_q)
                        + mpad_axi_pkg::addr_t'(win_col)) * `MPAD_WORD_BYTES;
    assign blk_addr_o = dst_q + (mpad_axi_pkg::addr_t'(blk_row_q)
                        * mpad_axi_pkg::addr_t'(n_q + 6'd2)
                        + mpad_axi_pkg::addr_t'(blk_col_q)) * `MPAD_WORD_BYTES;

    assign fetch_req_o = fetch_req_q;
    assign store_req_o = store_req_q;
    assign blk_o       = blk_q;
    assign done_o      = done_q;

endmodule

//--- hdl/mpad_window_reader.sv
/*
 * Window reader: three INCR read bursts, one per window row,
 * collected into the 3x3 window buffer
 */
`timescale 1ns/1ps
`include "mpad_macros.svh"

module mpad_window_reader (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     fetch_req_i,
    input  mpad_axi_pkg::addr_t      win_addr_i,
    input  mpad_axi_pkg::addr_t      row_pitch_i,
    output logic                     fetch_done_o,
    output mpad_engine_pkg::window_t win_o,

    output mpad_axi_pkg::addr_t      araddr_o,
    output mpad_axi_pkg::len_t       arlen_o,
    output logic                     arvalid_o,
    input  logic                     arready_i,
    input  mpad_axi_pkg::data_t      rdata_i,
    input  logic                     rlast_i,
    input  logic                     rvalid_i,
    output logic                     rready_o
);

    mpad_engine_pkg::rd_state_e state_q;
    logic [1:0]                 row_q;     // Burst number within the window
    logic [3:0]                 beat_q;    // Buffer write position
    logic                       done_q;
    mpad_axi_pkg::addr_t        addr_q;
    mpad_axi_pkg::addr_t        pitch_q;
    mpad_engine_pkg::window_t   win_q;

    logic r_beat;
    logic last_row;

    assign r_beat   = (state_q == mpad_engine_pkg::RD_DATA) && rvalid_i;
    assign last_row = (row_q == 2'(`MPAD_WIN_DIM - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mpad_engine_pkg::RD_IDLE;
            row_q   <= '0;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                mpad_engine_pkg::RD_IDLE: begin
                    if (fetch_req_i) begin
                        row_q   <= '0;
                        beat_q  <= '0;
                        state_q <= mpad_engine_pkg::RD_ADDR;
                    end
                end
                mpad_engine_pkg::RD_ADDR: begin
                    if (arready_i) state_q <= mpad_engine_pkg::RD_DATA;
                end
                mpad_engine_pkg::RD_DATA: begin
                    if (rvalid_i) begin
                        beat_q <= beat_q + 4'd1;
                        if (rlast_i && last_row) begin
                            done_q  <= 1'b1;   // Window complete
                            state_q <= mpad_engine_pkg::RD_IDLE;
                        end else if (rlast_i) begin
                            row_q   <= row_q + 2'd1;
                            state_q <= mpad_engine_pkg::RD_ADDR;
                        end
                    end
                end
                default: state_q <= mpad_engine_pkg::RD_IDLE;
            endcase
        end
    end

    // Burst address and window words
    always_ff @(posedge clk) begin
        if (state_q == mpad_engine_pkg::RD_IDLE && fetch_req_i) begin
            addr_q  <= win_addr_i;
            pitch_q <= row_pitch_i;
        end else if (r_beat && rlast_i) begin
            addr_q <= addr_q + pitch_q;   // Next source row
        end
        if (r_beat) win_q[beat_q] <= rdata_i;
    end

    assign araddr_o  = addr_q;
    assign arvalid_o = (state_q == mpad_engine_pkg::RD_ADDR);
    // Length is only presented alongside arvalid
    assign arlen_o   = arvalid_o ? mpad_axi_pkg::len_t'(`MPAD_WIN_DIM - 1) : '0;
    assign rready_o  = (state_q == mpad_engine_pkg::RD_DATA);

    assign fetch_done_o = done_q;
    assign win_o        = win_q;

endmodule

//--- mpad_dma.f
+incdir+hdl
hdl/mpad_axi_pkg.sv
hdl/mpad_engine_pkg.sv
hdl/mpad_window_reader.sv
hdl/mpad_block_writer.sv
hdl/mpad_tile_ctrl.sv
hdl/mpad_dma_top.sv
dv/mpad_dma_asserts.sv
dv/mpad_dma_tb.sv
